// ==== build.f ====
chol_pkg.sv
array_div.sv
cholesky_block.sv
lt_block.sv
mat_mult.sv
inverse.sv
tb_inverse.sv

// ==== Bender.yml ====
package:
  name: inverse

sources:
  - chol_pkg.sv
  - array_div.sv
  - cholesky_block.sv
  - lt_block.sv
  - mat_mult.sv
  - inverse.sv
  - target: test
    files:
      - tb_inverse.sv

// ==== tb_inverse.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// exact bit match against a model with the same truncation rules
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_inverse;
	import chol_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int SEED = 50676;
	localparam int NUM_DIAG = 2;
	localparam int NUM_RANDOM = 8;
	localparam int NUM_B2B = 4;
	localparam int NUM_MATS = 1 + NUM_DIAG + NUM_RANDOM + NUM_B2B;
	localparam int WATCHDOG_CYCLES = NUM_MATS * (N * N * (WIDTH + FRAC + 10) + 200);
	// 0.25, 1, 4, 16 and 64, all with exact roots and reciprocals
	localparam data_t DIAG_VALS [5] = '{32'sd1024, 32'sd4096, 32'sd16384, 32'sd65536,
		32'sd262144};

	logic i;
	logic arst_n;
	mat_t in_mat;
	logic in_valid;
	logic in_ready;
	mat_t out_mat;
	logic out_valid;
	logic out_ready;

	mat_t exp_q [$];
	mat_t exp_head;
	int exp_count;
	logic in_flight;
	mat_t m;
	mat_t e;

	inverse u_inverse (
		.i(i), .arst_n(arst_n), .in_mat(in_mat), .in_valid(in_valid), .in_ready(in_ready),
		.out_mat(out_mat), .out_valid(out_valid), .out_ready(out_ready)
	);

	initial begin
		i = 1'b0;
		forever #(CLK_PERIOD / 2) i = ~i;
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Regression failed");
		$fatal(1);
	endtask

	// truncating fixed-point arithmetic of the model
	function automatic data_t fixed_mul(input data_t a, input data_t b);
		return data_t'((longint'(a) * longint'(b)) >>> FRAC);
	endfunction

	function automatic data_t fixed_div(input data_t a, input data_t b);
		return data_t'((longint'(a) <<< FRAC) / longint'(b));
	endfunction

	// binary search for the floor root
	function automatic data_t floor_root(input data_t v);
		longint rad;
		longint lo;
		longint hi;
		longint mid;
		rad = longint'(v) <<< FRAC;
		lo = 0;
		hi = longint'(1) << ROOT_W;
		while (hi - lo > 1) begin
			mid = (lo + hi) / 2;
			if (mid * mid <= rad)
				lo = mid;
			else
				hi = mid;
		end
		return data_t'(lo);
	endfunction

	function automatic mat_t ref_inverse(input mat_t a);
		mat_t l;
		mat_t x;
		mat_t p;
		data_t s;
		l = '0;
		x = '0;
		for (int j = 0; j < N; j++) begin
			s = a[j][j];
			for (int k = 0; k < j; k++)
				s = s - fixed_mul(l[j][k], l[j][k]);
			l[j][j] = floor_root(s);
			for (int r = j + 1; r < N; r++) begin
				s = a[r][j];
				for (int k = 0; k < j; k++)
					s = s - fixed_mul(l[r][k], l[j][k]);
				l[r][j] = fixed_div(s, l[j][j]);
			end
		end
		// forward substitution, row by row
		for (int r = 0; r < N; r++) begin
			x[r][r] = fixed_div(ONE, l[r][r]);
			for (int c = 0; c < r; c++) begin
				s = '0;
				for (int k = c; k < r; k++)
					s = s - fixed_mul(l[r][k], x[k][c]);
				x[r][c] = fixed_mul(x[r][r], s);
			end
		end
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				s = '0;
				for (int k = 0; k < N; k++)
					s = s + fixed_mul(x[k][r], x[k][c]);
				p[r][c] = s;
			end
		end
		return p;
	endfunction

	// M*M^T + 4I with small integer entries in M
	function automatic mat_t random_spd();
		int mm [N][N];
		int s;
		mat_t a;
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				mm[r][c] = int'($urandom_range(6)) - 3;
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				s = (r == c) ? 4 : 0;
				for (int k = 0; k < N; k++)
					s = s + mm[r][k] * mm[c][k];
				a[r][c] = data_t'(s * (1 << FRAC));
			end
		end
		return a;
	endfunction

	function automatic void refresh_expected();
		exp_count = exp_q.size();
		exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
	endfunction

	// leaves in_valid high after the transfer
	task automatic send_matrix(input mat_t mat, input mat_t expected);
		@(negedge i);
		in_mat = mat;
		in_valid = 1'b1;
		while (!in_ready)
			@(negedge i);
		@(posedge i);
		exp_q.push_back(expected);
		refresh_expected();
		in_flight = 1'b1;
	endtask

	task automatic drop_valid();
		@(negedge i);
		in_valid = 1'b0;
	endtask

	task automatic take_result(input int stall);
		@(negedge i);
		while (!out_valid)
			@(negedge i);
		repeat (stall) @(negedge i);
		out_ready = 1'b1;
		@(posedge i);
		if (exp_q.size() > 0)
			void'(exp_q.pop_front());
		refresh_expected();
		@(negedge i);
		out_ready = 1'b0;
		in_flight = 1'b0;
	endtask

	task automatic run_one(input mat_t mat, input mat_t expected, input int stall);
		send_matrix(mat, expected);
		drop_valid();
		take_result(stall);
	endtask

	initial begin
		void'($urandom(SEED));
		in_mat = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		in_flight = 1'b0;
		refresh_expected();
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge i);
		@(negedge i);
		arst_n = 1'b1;

		// identity
		m = '0;
		for (int r = 0; r < N; r++)
			m[r][r] = ONE;
		run_one(m, m, 0);

		// powers of two on the diagonal, exact reciprocals expected
		for (int t = 0; t < NUM_DIAG; t++) begin
			m = '0;
			e = '0;
			for (int r = 0; r < N; r++) begin
				m[r][r] = DIAG_VALS[$urandom_range(4)];
				e[r][r] = data_t'((longint'(ONE) * longint'(ONE)) / longint'(m[r][r]));
			end
			run_one(m, e, int'($urandom_range(3)));
		end

		// random SPD with back-pressure on the output
		for (int t = 0; t < NUM_RANDOM; t++) begin
			m = random_spd();
			run_one(m, ref_inverse(m), int'($urandom_range(6, 1)));
		end

		// in_valid held high across back-to-back matrices
		fork
			begin
				for (int t = 0; t < NUM_B2B; t++) begin
					m = random_spd();
					send_matrix(m, ref_inverse(m));
				end
				drop_valid();
			end
			begin
				for (int t = 0; t < NUM_B2B; t++)
					take_result(int'($urandom_range(3)));
			end
		join

		@(negedge i);
		$display("Regression passed");
		$finish;
	end

	initial begin
		repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge i);
		abort_run("Timeout: the DUT did not return all results in time");
	end

	a_reset_idle: assert property (@(posedge i) $rose(arst_n) |-> in_ready && !out_valid)
		else abort_run($sformatf("Fail at %0t ns: in_ready or out_valid wrong after reset",
			$time));

	a_result: assert property (@(posedge i) disable iff (!arst_n)
		out_valid && out_ready |-> exp_count > 0 && out_mat == exp_head)
		else abort_run($sformatf("Fail at %0t ns: out_mat differs from the expected inverse",
			$time));

	a_hold: assert property (@(posedge i) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && !in_ready && $stable(out_mat))
		else abort_run($sformatf("Fail at %0t ns: output not held under back-pressure",
			$time));

	a_busy: assert property (@(posedge i) disable iff (!arst_n)
		in_flight |-> !in_ready)
		else abort_run($sformatf("Fail at %0t ns: in_ready high while a matrix is in flight",
			$time));

	a_valid_owner: assert property (@(posedge i) disable iff (!arst_n)
		out_valid |-> in_flight)
		else abort_run($sformatf("Fail at %0t ns: out_valid without a matrix in flight",
			$time));

	a_accept: assert property (@(posedge i) disable iff (!arst_n)
		in_valid && in_ready |=> !in_ready)
		else abort_run($sformatf("Fail at %0t ns: in_ready stayed high after a transfer",
			$time));

endmodule

`default_nettype wire

// ==== inverse.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// one matrix in flight; in_ready only while idle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module inverse (
	input logic i,
	input logic arst_n,
	input chol_pkg::mat_t in_mat,
	input logic in_valid,
	output logic in_ready,
	output chol_pkg::mat_t out_mat,
	output logic out_valid,
	input logic out_ready
);
	import chol_pkg::*;

	seq_state_t state_q;
	mat_t a_q;
	mat_t l;
	mat_t x;
	mat_t p;
	logic chol_start;
	logic lt_start;
	logic mm_start;
	logic chol_done;
	logic lt_done;
	logic mm_done;
	div_req_t chol_req;
	div_req_t lt_req;
	div_req_t div_req;
	logic chol_div_valid;
	logic lt_div_valid;
	logic div_valid;
	logic div_ready;
	logic chol_div_ready;
	logic lt_div_ready;
	logic div_done;
	logic chol_div_done;
	logic lt_div_done;
	data_t div_quotient;

	assign in_ready = state_q == IDLE;
	assign out_valid = state_q == HOLD;

	// sequencer, one block at a time
	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= IDLE;
			chol_start <= 1'b0;
			lt_start <= 1'b0;
			mm_start <= 1'b0;
		end else begin
			chol_start <= 1'b0;
			lt_start <= 1'b0;
			mm_start <= 1'b0;
			case (state_q)
				IDLE: if (in_valid) begin
					state_q <= FACTOR;
					chol_start <= 1'b1;
				end
				FACTOR: if (chol_done) begin
					state_q <= TRI_INV;
					lt_start <= 1'b1;
				end
				TRI_INV: if (lt_done) begin
					state_q <= PRODUCT;
					mm_start <= 1'b1;
				end
				PRODUCT: if (mm_done) state_q <= HOLD;
				HOLD: if (out_ready) state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i) begin
		if (in_valid && in_ready)
			a_q <= in_mat;
		if (state_q == PRODUCT && mm_done)
			out_mat <= p;
	end

	// divider goes to whichever block owns the current state
	always_comb begin
		div_req = '0;
		div_valid = 1'b0;
		chol_div_ready = 1'b0;
		lt_div_ready = 1'b0;
		chol_div_done = 1'b0;
		lt_div_done = 1'b0;
		case (state_q)
			FACTOR: begin
				div_req = chol_req;
				div_valid = chol_div_valid;
				chol_div_ready = div_ready;
				chol_div_done = div_done;
			end
			TRI_INV: begin
				div_req = lt_req;
				div_valid = lt_div_valid;
				lt_div_ready = div_ready;
				lt_div_done = div_done;
			end
			default: ;
		endcase
	end

	cholesky_block u_cholesky_block (
		.i(i), .arst_n(arst_n), .start(chol_start), .a(a_q), .l(l), .done(chol_done),
		.div_req(chol_req), .div_valid(chol_div_valid), .div_ready(chol_div_ready),
		.div_quotient(div_quotient), .div_done(chol_div_done)
	);

	lt_block u_lt_block (
		.i(i), .arst_n(arst_n), .start(lt_start), .l(l), .x(x), .done(lt_done),
		.div_req(lt_req), .div_valid(lt_div_valid), .div_ready(lt_div_ready),
		.div_quotient(div_quotient), .div_done(lt_div_done)
	);

	array_div u_array_div (
		.i(i), .arst_n(arst_n), .req(div_req), .req_valid(div_valid),
		.req_ready(div_ready), .quotient(div_quotient), .res_valid(div_done)
	);

	mat_mult u_mat_mult (
		.i(i), .arst_n(arst_n), .start(mm_start), .x(x), .p(p), .done(mm_done)
	);

	// result held under back-pressure
	a_out_stable: assert property (@(posedge i) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_mat));

endmodule

`default_nettype wire

// ==== mat_mult.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// p = transpose(x) * x, one product per cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module mat_mult (
	input logic i,
	input logic arst_n,
	input logic start,
	input chol_pkg::mat_t x,
	output chol_pkg::mat_t p,
	output logic done
);
	import chol_pkg::*;

	typedef enum logic {M_IDLE, M_RUN} mm_state_t;

	mm_state_t state_q;
	idx_t r_q;
	idx_t c_q;
	idx_t k_q;
	data_t acc_q;
	data_t sum;
	logic last_k;

	// column r of x against column c of x
	assign sum = acc_q + fx_mul(x[k_q][r_q], x[k_q][c_q]);
	assign last_k = k_q == idx_t'(N - 1);

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= M_IDLE;
			r_q <= '0;
			c_q <= '0;
			k_q <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state_q)
				M_IDLE: if (start) begin
					state_q <= M_RUN;
					r_q <= '0;
					c_q <= '0;
					k_q <= '0;
				end
				M_RUN: begin
					if (!last_k) begin
						k_q <= k_q + 1'b1;
					end else begin
						k_q <= '0;
						if (c_q == idx_t'(N - 1)) begin
							c_q <= '0;
							if (r_q == idx_t'(N - 1)) begin
								state_q <= M_IDLE;
								done <= 1'b1;
							end else begin
								r_q <= r_q + 1'b1;
							end
						end else begin
							c_q <= c_q + 1'b1;
						end
					end
				end
				default: state_q <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge i) begin
		if (state_q == M_IDLE) begin
			acc_q <= '0;
		end else if (last_k) begin
			p[r_q][c_q] <= sum;
			acc_q <= '0;
		end else begin
			acc_q <= sum;
		end
	end

endmodule

`default_nettype wire

// ==== lt_block.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// l must be lower triangular with a non-zero diagonal
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module lt_block (
	input logic i,
	input logic arst_n,
	input logic start,
	input chol_pkg::mat_t l,
	output chol_pkg::mat_t x,
	output logic done,
	output chol_pkg::div_req_t div_req,
	output logic div_valid,
	input logic div_ready,
	input chol_pkg::data_t div_quotient,
	input logic div_done
);
	import chol_pkg::*;

	typedef enum logic [1:0] {T_IDLE, T_DREQ, T_DWAIT, T_ACC} lt_state_t;

	lt_state_t state_q;
	idx_t r_q;
	idx_t c_q;
	idx_t k_q;
	data_t acc_q;
	data_t mul_a;
	data_t mul_b;
	data_t prod;
	logic acc_end;

	// accumulate L_rk * X_kc, then scale the negated sum by X_rr
	assign acc_end = k_q == r_q;
	assign mul_a = acc_end ? x[r_q][r_q] : l[r_q][k_q];
	assign mul_b = acc_end ? acc_q : x[k_q][c_q];
	assign prod = fx_mul(mul_a, mul_b);

	assign div_req = '{dividend: ONE, divisor: l[r_q][r_q]};
	assign div_valid = state_q == T_DREQ;

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= T_IDLE;
			r_q <= '0;
			c_q <= '0;
			k_q <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state_q)
				T_IDLE: if (start) begin
					state_q <= T_DREQ;
					r_q <= '0;
				end
				T_DREQ: if (div_ready) state_q <= T_DWAIT;
				T_DWAIT: if (div_done) begin
					// first row has nothing below the diagonal
					if (r_q == '0) begin
						r_q <= r_q + 1'b1;
						state_q <= T_DREQ;
					end else begin
						state_q <= T_ACC;
						c_q <= '0;
						k_q <= '0;
					end
				end
				T_ACC: begin
					if (!acc_end) begin
						k_q <= k_q + 1'b1;
					end else if (c_q == r_q - 1'b1) begin
						if (r_q == idx_t'(N - 1)) begin
							state_q <= T_IDLE;
							done <= 1'b1;
						end else begin
							r_q <= r_q + 1'b1;
							state_q <= T_DREQ;
						end
					end else begin
						c_q <= c_q + 1'b1;
						k_q <= c_q + 1'b1;
					end
				end
				default: state_q <= T_IDLE;
			endcase
		end
	end

	always_ff @(posedge i) begin
		case (state_q)
			T_IDLE: if (start) x <= '0;
			T_DWAIT: if (div_done) begin
				x[r_q][r_q] <= div_quotient;
				acc_q <= '0;
			end
			T_ACC: begin
				if (!acc_end) begin
					acc_q <= acc_q - prod;
				end else begin
					x[r_q][c_q] <= prod;
					acc_q <= '0;
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== cholesky_block.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// input assumed SPD; a must stay stable from start to done
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module cholesky_block (
	input logic i,
	input logic arst_n,
	input logic start,
	input chol_pkg::mat_t a,
	output chol_pkg::mat_t l,
	output logic done,
	output chol_pkg::div_req_t div_req,
	output logic div_valid,
	input logic div_ready,
	input chol_pkg::data_t div_quotient,
	input logic div_done
);
	import chol_pkg::*;

	typedef enum logic [2:0] {C_IDLE, C_ACC, C_ROOT, C_DREQ, C_DWAIT} chol_state_t;

	chol_state_t state_q;
	idx_t j_q;
	idx_t r_q;
	idx_t k_q;
	data_t acc_q;
	data_t prod;
	logic [2*ROOT_W-1:0] rad_q;
	logic [2*ROOT_W-1:0] root_sq;
	logic [ROOT_W-1:0] root_q;
	logic [ROOT_W-1:0] root_try;
	logic [ROOT_W-1:0] root_nxt;
	logic [ROOT_BIT_W-1:0] bit_q;
	logic diag;
	logic acc_end;

	// one multiplier, L_rk * L_jk; on the diagonal r equals j
	assign prod = fx_mul(l[r_q][k_q], l[j_q][k_q]);
	assign diag = r_q == j_q;
	assign acc_end = k_q == j_q;

	// bit by bit floor root
	assign root_try = root_q | (ROOT_W'(1) << bit_q);
	assign root_sq = root_try * root_try;
	assign root_nxt = (root_sq <= rad_q) ? root_try : root_q;

	assign div_req = '{dividend: acc_q, divisor: l[j_q][j_q]};
	assign div_valid = state_q == C_DREQ;

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= C_IDLE;
			j_q <= '0;
			r_q <= '0;
			k_q <= '0;
			bit_q <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state_q)
				C_IDLE: if (start) begin
					state_q <= C_ACC;
					j_q <= '0;
					r_q <= '0;
					k_q <= '0;
				end
				C_ACC: begin
					if (!acc_end) begin
						k_q <= k_q + 1'b1;
					end else if (diag) begin
						state_q <= C_ROOT;
						bit_q <= ROOT_BIT_W'(ROOT_W - 1);
					end else begin
						state_q <= C_DREQ;
					end
				end
				C_ROOT: begin
					bit_q <= bit_q - 1'b1;
					if (bit_q == '0) begin
						if (j_q == idx_t'(N - 1)) begin
							state_q <= C_IDLE;
							done <= 1'b1;
						end else begin
							state_q <= C_ACC;
							r_q <= j_q + 1'b1;
							k_q <= '0;
						end
					end
				end
				C_DREQ: if (div_ready) state_q <= C_DWAIT;
				C_DWAIT: if (div_done) begin
					state_q <= C_ACC;
					k_q <= '0;
					// last row of the column moves to the next diagonal
					if (r_q == idx_t'(N - 1)) begin
						j_q <= j_q + 1'b1;
						r_q <= j_q + 1'b1;
					end else begin
						r_q <= r_q + 1'b1;
					end
				end
				default: state_q <= C_IDLE;
			endcase
		end
	end

	always_ff @(posedge i) begin
		case (state_q)
			C_IDLE: if (start) begin
				l <= '0;
				acc_q <= a[0][0];
			end
			C_ACC: begin
				if (!acc_end) begin
					acc_q <= acc_q - prod;
				end else if (diag) begin
					rad_q <= {acc_q, {FRAC{1'b0}}};
					root_q <= '0;
				end
			end
			C_ROOT: begin
				root_q <= root_nxt;
				if (bit_q == '0) begin
					l[j_q][j_q] <= data_t'(root_nxt);
					if (j_q != idx_t'(N - 1))
						acc_q <= a[j_q + 1'b1][j_q];
				end
			end
			C_DWAIT: if (div_done) begin
				l[r_q][j_q] <= div_quotient;
				if (r_q == idx_t'(N - 1))
					acc_q <= a[j_q + 1'b1][j_q + 1'b1];
				else
					acc_q <= a[r_q + 1'b1][j_q];
			end
			default: ;
		endcase
	end

	// a negative radicand means the input was not SPD
	a_rad_pos: assert property (@(posedge i) disable iff (!arst_n)
		state_q == C_ACC && acc_end && diag |-> acc_q >= 0);

endmodule

`default_nettype wire

// ==== array_div.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// one request at a time; result WIDTH+FRAC+1 cycles after accept
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module array_div (
	input logic i,
	input logic arst_n,
	input chol_pkg::div_req_t req,
	input logic req_valid,
	output logic req_ready,
	output chol_pkg::data_t quotient,
	output logic res_valid
);
	import chol_pkg::*;

	logic busy_q;
	logic [DIV_CNT_W-1:0] cnt_q;
	logic neg_q;
	logic [WIDTH-1:0] dvs_q;
	logic [WIDTH-1:0] rem_q;
	logic [DIV_STEPS-1:0] quo_q;
	logic [WIDTH-1:0] dvd_mag;
	logic [WIDTH-1:0] dvs_mag;
	logic [WIDTH:0] rem_sh;
	logic fits;

	// magnitudes, sign restored at the end
	assign dvd_mag = req.dividend[WIDTH-1] ? -req.dividend : req.dividend;
	assign dvs_mag = req.divisor[WIDTH-1] ? -req.divisor : req.divisor;
	assign req_ready = !busy_q;

	// restoring step
	assign rem_sh = {rem_q, quo_q[DIV_STEPS-1]};
	assign fits = rem_sh >= {1'b0, dvs_q};

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			busy_q <= 1'b0;
			cnt_q <= '0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= 1'b0;
			if (req_valid && req_ready) begin
				busy_q <= 1'b1;
				cnt_q <= DIV_CNT_W'(DIV_STEPS);
			end else if (busy_q) begin
				if (cnt_q == '0) begin
					busy_q <= 1'b0;
					res_valid <= 1'b1;
				end else begin
					cnt_q <= cnt_q - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i) begin
		if (req_valid && req_ready) begin
			neg_q <= req.dividend[WIDTH-1] ^ req.divisor[WIDTH-1];
			dvs_q <= dvs_mag;
			rem_q <= '0;
			// dividend pre-shifted by the fraction width
			quo_q <= {dvd_mag, {FRAC{1'b0}}};
		end else if (busy_q && cnt_q != '0) begin
			rem_q <= fits ? WIDTH'(rem_sh - {1'b0, dvs_q}) : rem_sh[WIDTH-1:0];
			quo_q <= {quo_q[DIV_STEPS-2:0], fits};
		end else if (busy_q) begin
			quotient <= neg_q ? -data_t'(quo_q[WIDTH-1:0]) : data_t'(quo_q[WIDTH-1:0]);
		end
	end

	// the client blocks must never divide by zero
	a_no_zero_div: assert property (@(posedge i) disable iff (!arst_n)
		req_valid && req_ready |-> req.divisor != '0);

endmodule

`default_nettype wire

// ==== chol_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// signed fixed point, no saturation; sizes fixed for a 3x3 matrix
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package chol_pkg;

	// matrix order and word format
	localparam int N = 3;
	localparam int WIDTH = 32;
	localparam int FRAC = 12;
	localparam int IDX_W = $clog2(N);

	// divider steps, one quotient bit each
	localparam int DIV_STEPS = WIDTH + FRAC;
	localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);

	// root of a radicand widened by FRAC bits
	localparam int ROOT_W = (WIDTH + FRAC) / 2;
	localparam int ROOT_BIT_W = $clog2(ROOT_W);

	typedef logic signed [WIDTH-1:0] data_t;
	typedef logic [IDX_W-1:0] idx_t;

	localparam data_t ONE = data_t'(1 << FRAC);

	// row then column
	typedef data_t [N-1:0][N-1:0] mat_t;

	typedef struct packed {
		data_t dividend;
		data_t divisor;
	} div_req_t;

	typedef enum logic [2:0] {IDLE, FACTOR, TRI_INV, PRODUCT, HOLD} seq_state_t;

	// full product, arithmetic shift truncates
	function automatic data_t fx_mul(input data_t a, input data_t b);
		logic signed [2*WIDTH-1:0] full;
		full = a * b;
		return data_t'(full >>> FRAC);
	endfunction

endpackage

`default_nettype wire
